/* rtl/booth_mult_pkg.sv */
package booth_mult_pkg;

  // One overlapping Booth triplet {b[2i+1], b[2i], b[2i-1]}
  typedef logic [2:0] booth_digit_t;

  // Mantissa width of single precision, hidden bit included
  localparam int DEF_OP_WIDTH = 24;

  // Largest partial count the width tracking below can follow
  localparam int MAX_PAR_NUM = 64;

  // Widest of three vectors
  function automatic int max_width(input int a, input int b, input int c);
    int m;
    m = (a >= b) ? a : b;
    return (m >= c) ? m : c;
  endfunction

  // Vectors left after a number of 3-to-2 stages
  // Every full group of three turns into two, leftovers pass through
  function automatic int tree_vec_num(input int par_num, input int stage);
    int n;
    n = par_num;
    for (int s = 0; s < stage; s++) begin
      n = 2 * (n / 3) + n % 3;
    end
    return n;
  endfunction

  // 3-to-2 stages needed to bring par_num vectors down to two
  function automatic int tree_stage_num(input int par_num);
    int n;
    int stages;
    n = par_num;
    stages = 0;
    while (n > 2) begin
      n = tree_vec_num(n, 1);
      stages++;
    end
    return stages;
  endfunction

  // Width of vector idx at the input of stage
  // Carry slot of a group sits at 2g and is one bit wider than the sum at 2g+1
  function automatic int tree_vec_width(input int par_num, input int par_width,
                                        input int shif_width, input int stage,
                                        input int idx);
    int w  [MAX_PAR_NUM];
    int nw [MAX_PAR_NUM];
    int n;
    int grp;
    for (int j = 0; j < MAX_PAR_NUM; j++) begin
      w[j]  = (j < par_num) ? par_width + j * shif_width : 0;
      nw[j] = 0;
    end
    n = par_num;
    for (int s = 0; s < stage; s++) begin
      grp = n / 3;
      for (int g = 0; g < grp; g++) begin
        nw[2 * g + 1] = max_width(w[3 * g], w[3 * g + 1], w[3 * g + 2]);
        nw[2 * g]     = nw[2 * g + 1] + 1;
      end
      for (int r = 0; r < n % 3; r++) begin
        nw[2 * grp + r] = w[3 * grp + r];
      end
      for (int j = 0; j < MAX_PAR_NUM; j++) begin
        w[j] = nw[j];
      end
      n = tree_vec_num(n, 1);
    end
    return w[idx];
  endfunction

  // Common width of the two vectors leaving the tree
  function automatic int tree_out_width(input int par_num, input int par_width,
                                        input int shif_width);
    int last;
    last = tree_stage_num(par_num);
    return max_width(tree_vec_width(par_num, par_width, shif_width, last, 0),
                     tree_vec_width(par_num, par_width, shif_width, last, 1), 0);
  endfunction

endpackage

/* rtl/booth_pp_gen.sv */
module booth_pp_gen #(
  parameter int OP_WIDTH = 24
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  input  logic signed [OP_WIDTH-1:0] op_a,
  input  logic signed [OP_WIDTH-1:0] op_b,
  output logic        [OP_WIDTH+1:0] pp [OP_WIDTH/2],
  output logic                       pp_valid
);
  import booth_mult_pkg::*;

  localparam int PP_NUM   = OP_WIDTH / 2;
  localparam int PP_WIDTH = OP_WIDTH + 2;

  // One partial product, wide enough for -2 times the most negative operand
  typedef logic [PP_WIDTH-1:0] pp_t;

  logic signed [OP_WIDTH-1:0] a_reg;
  logic signed [OP_WIDTH-1:0] b_reg;

  ////////////////////
  // Operand register
  ////////////////////

  // Operands only move on an accepted pair
  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_reg <= op_a;
      b_reg <= op_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= in_valid;
    end
  end

  ////////////////////
  // Booth recoding
  ////////////////////

  // Multiplicand multiples, all sign extended to the partial width
  pp_t a_pos;
  pp_t a_neg;
  pp_t a_dbl;
  pp_t a_dbl_neg;

  assign a_pos     = {{2{a_reg[OP_WIDTH-1]}}, a_reg};
  assign a_neg     = -a_pos;
  assign a_dbl     = {a_pos[PP_WIDTH-2:0], 1'b0};
  assign a_dbl_neg = -a_dbl;

  // Implicit zero below the multiplier LSB
  logic [OP_WIDTH:0] b_pad;

  assign b_pad = {b_reg, 1'b0};

  for (genvar i = 0; i < PP_NUM; i++) begin : g_digit
    booth_digit_t digit;

    // Triplet {b[2i+1], b[2i], b[2i-1]} sits at b_pad[2i+2:2i]
    assign digit = b_pad[2*i +: 3];

    always_comb begin
      case (digit)
        3'b001, 3'b010: pp[i] = a_pos;
        3'b011:         pp[i] = a_dbl;
        3'b100:         pp[i] = a_dbl_neg;
        3'b101, 3'b110: pp[i] = a_neg;
        // 000 and 111 both select zero
        default:        pp[i] = '0;
      endcase
    end
  end

endmodule

/* rtl/csa_3to2.sv */
module csa_3to2 #(
  parameter int WIDTH_1 = 8,
  parameter int WIDTH_2 = 8,
  parameter int WIDTH_3 = 8,
  localparam int MAX_W = booth_mult_pkg::max_width(WIDTH_1, WIDTH_2, WIDTH_3)
) (
  input  logic [WIDTH_1-1:0] in_op1,
  input  logic [WIDTH_2-1:0] in_op2,
  input  logic [WIDTH_3-1:0] in_op3,
  output logic [MAX_W:0]     out_c,
  output logic [MAX_W-1:0]   out_s
);

  // Inputs brought to a common signed width
  logic [MAX_W-1:0] op1_ext;
  logic [MAX_W-1:0] op2_ext;
  logic [MAX_W-1:0] op3_ext;

  assign op1_ext = MAX_W'($signed(in_op1));
  assign op2_ext = MAX_W'($signed(in_op2));
  assign op3_ext = MAX_W'($signed(in_op3));

  // Bitwise full adder sum
  assign out_s = op1_ext ^ op2_ext ^ op3_ext;

  // Majority carry, one position up
  // Its top bit takes the negative weight, so the pair stays exact
  assign out_c = {(op1_ext & op2_ext) | (op1_ext & op3_ext) | (op2_ext & op3_ext), 1'b0};

endmodule

/* rtl/csa_nto2.sv */
module csa_nto2 #(
  parameter int PAR_NUM    = 12,
  parameter int PAR_WIDTH  = 26,
  parameter int SHIF_WIDTH = 2,
  localparam int OUT_WIDTH = booth_mult_pkg::tree_out_width(PAR_NUM, PAR_WIDTH, SHIF_WIDTH)
) (
  input  logic [PAR_WIDTH-1:0] in_par  [PAR_NUM],
  output logic [OUT_WIDTH-1:0] out_par [2]
);
  import booth_mult_pkg::*;

  localparam int STAGE_NUM = tree_stage_num(PAR_NUM);

  ////////////////////
  // Level storage
  ////////////////////

  // Level s holds the vectors entering stage s
  // Last level holds the two vectors leaving the tree
  for (genvar s = 0; s <= STAGE_NUM; s++) begin : lvl
    for (genvar k = 0; k < tree_vec_num(PAR_NUM, s); k++) begin : vec
      logic [tree_vec_width(PAR_NUM, PAR_WIDTH, SHIF_WIDTH, s, k)-1:0] v;
    end
  end

  // Partial j moves up by j shift steps
  // Zeros are appended at the bottom, so widths differ on entry
  for (genvar j = 0; j < PAR_NUM; j++) begin : g_shift
    if (j == 0) begin : g_base
      assign lvl[0].vec[0].v = in_par[0];
    end else begin : g_pad
      assign lvl[0].vec[j].v = {in_par[j], {(j * SHIF_WIDTH){1'b0}}};
    end
  end

  ////////////////////
  // Reduction stages
  ////////////////////

  for (genvar s = 0; s < STAGE_NUM; s++) begin : stg
    localparam int N   = tree_vec_num(PAR_NUM, s);
    localparam int GRP = N / 3;

    // Full groups of three, carry lands at 2g and sum at 2g+1
    for (genvar g = 0; g < GRP; g++) begin : grp
      csa_3to2 #(
        .WIDTH_1 (tree_vec_width(PAR_NUM, PAR_WIDTH, SHIF_WIDTH, s, 3 * g)),
        .WIDTH_2 (tree_vec_width(PAR_NUM, PAR_WIDTH, SHIF_WIDTH, s, 3 * g + 1)),
        .WIDTH_3 (tree_vec_width(PAR_NUM, PAR_WIDTH, SHIF_WIDTH, s, 3 * g + 2))
      ) u_csa (
        .in_op1 (lvl[s].vec[3 * g].v),
        .in_op2 (lvl[s].vec[3 * g + 1].v),
        .in_op3 (lvl[s].vec[3 * g + 2].v),
        .out_c  (lvl[s + 1].vec[2 * g].v),
        .out_s  (lvl[s + 1].vec[2 * g + 1].v)
      );
    end

    // One or two leftovers go straight to the next level
    for (genvar r = 0; r < N % 3; r++) begin : pass
      assign lvl[s + 1].vec[2 * GRP + r].v = lvl[s].vec[3 * GRP + r].v;
    end
  end

  ////////////////////
  // Output alignment
  ////////////////////

  // Final pair may differ by a bit or two, sign extend both
  assign out_par[0] = OUT_WIDTH'($signed(lvl[STAGE_NUM].vec[0].v));
  assign out_par[1] = OUT_WIDTH'($signed(lvl[STAGE_NUM].vec[1].v));

endmodule

/* rtl/product_adder.sv */
module product_adder #(
  parameter int IN_WIDTH   = 50,
  parameter int PROD_WIDTH = 48
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pp_valid,
  input  logic [IN_WIDTH-1:0]   sum_vec,
  input  logic [IN_WIDTH-1:0]   carry_vec,
  output logic [PROD_WIDTH-1:0] product,
  output logic                  out_valid
);

  // Carry-propagate sum of the tree output
  typedef logic [IN_WIDTH-1:0] tree_t;

  tree_t full_sum;

  // Wraps modulo 2^IN_WIDTH, true product always fits the low bits
  assign full_sum = sum_vec + carry_vec;

  // Product holds between results, valid tracks the stage before
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      product   <= '0;
    end else begin
      out_valid <= pp_valid;
      if (pp_valid) begin
        product <= full_sum[PROD_WIDTH-1:0];
      end
    end
  end

endmodule

/* rtl/booth_mult.sv */
module booth_mult #(
  parameter int OP_WIDTH = booth_mult_pkg::DEF_OP_WIDTH
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  logic signed [OP_WIDTH-1:0]   op_a,
  input  logic signed [OP_WIDTH-1:0]   op_b,
  output logic                         out_valid,
  output logic        [2*OP_WIDTH-1:0] product
);
  import booth_mult_pkg::*;

  // Radix-4 gives one partial per two multiplier bits
  localparam int PP_NUM     = OP_WIDTH / 2;
  localparam int PP_WIDTH   = OP_WIDTH + 2;
  localparam int SHIF_WIDTH = 2;
  localparam int TREE_WIDTH = tree_out_width(PP_NUM, PP_WIDTH, SHIF_WIDTH);

  typedef logic [PP_WIDTH-1:0]   pp_t;
  typedef logic [TREE_WIDTH-1:0] tree_t;

  pp_t   pp [PP_NUM];
  logic  pp_valid;
  // Index 0 is the carry vector, index 1 the sum vector
  tree_t tree_vec [2];

  // Edge k, operands registered and recoded
  booth_pp_gen #(
    .OP_WIDTH (OP_WIDTH)
  ) u_pp_gen (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .op_a     (op_a),
    .op_b     (op_b),
    .pp       (pp),
    .pp_valid (pp_valid)
  );

  // Combinational between the two register stages
  csa_nto2 #(
    .PAR_NUM    (PP_NUM),
    .PAR_WIDTH  (PP_WIDTH),
    .SHIF_WIDTH (SHIF_WIDTH)
  ) u_tree (
    .in_par  (pp),
    .out_par (tree_vec)
  );

  // Edge k+1, product registered
  product_adder #(
    .IN_WIDTH   (TREE_WIDTH),
    .PROD_WIDTH (2 * OP_WIDTH)
  ) u_adder (
    .clk       (clk),
    .reset     (reset),
    .pp_valid  (pp_valid),
    .sum_vec   (tree_vec[1]),
    .carry_vec (tree_vec[0]),
    .product   (product),
    .out_valid (out_valid)
  );

endmodule

/* test/booth_mult_chk.sv */
module booth_mult_chk #(
  parameter int OP_WIDTH = booth_mult_pkg::DEF_OP_WIDTH
) (
  input logic                  clk,
  input logic                  reset,
  input logic                  in_valid,
  input logic                  out_valid,
  input logic [2*OP_WIDTH-1:0] product
);
  timeunit 1ns;
  timeprecision 1ps;
  import booth_mult_pkg::*;

  // Reduction depth between the two register stages, all of it combinational
  localparam int TREE_DEPTH = tree_stage_num(OP_WIDTH / 2);

  // Operand register, then product register
  assert property (@(posedge clk) disable iff (reset)
    (!$past(reset) && !$past(reset, 2)) |-> (out_valid == $past(in_valid, 2)))
    else $error("out_valid does not follow in_valid by two cycles");

  // Both valid stages are cleared, so nothing leaks out right after reset
  assert property (@(posedge clk) (reset || $past(reset)) |=> !out_valid)
    else $error("out_valid high during reset or in the cycle after it");

  // Product register loads only together with a result
  assert property (@(posedge clk) disable iff (reset) !out_valid |-> $stable(product))
    else $error("product changed while out_valid was low");

endmodule

bind booth_mult booth_mult_chk #(
  .OP_WIDTH (OP_WIDTH)
) u_chk (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .product   (product)
);

/* test/booth_mult_tb.sv */
module booth_mult_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int W             = 24;
  localparam int PW            = 2 * W;
  localparam int CLK_PERIOD    = 40;
  localparam int IDLE_CYCLES   = 4;
  localparam int CORNER_OPS    = 25;
  localparam int RAND_OPS      = 400;
  localparam int SPARSE_CYCLES = 400;
  localparam int DRAIN_CYCLES  = 8;
  localparam int TEST_CYCLES   = 2 + IDLE_CYCLES + CORNER_OPS + 1 + RAND_OPS
                                 + SPARSE_CYCLES + DRAIN_CYCLES;

  logic                clk;
  logic                reset;
  logic                in_valid;
  logic signed [W-1:0] op_a;
  logic signed [W-1:0] op_b;
  logic                out_valid;
  logic [PW-1:0]       product;

  logic [31:0]   rng_state;
  logic [PW-1:0] exp_q [$];
  int            cyc_q [$];
  int            cycle;
  int            err_count;
  int            check_count;
  // Last product the model expects at the port, zero out of reset
  logic [PW-1:0] held_product;

  booth_mult #(
    .OP_WIDTH (W)
  ) u_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .out_valid (out_valid),
    .product   (product)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 0, 1, -1, most positive, most negative
  function automatic logic [W-1:0] corner_value(input int i);
    case (i)
      0:       return '0;
      1:       return W'(1);
      2:       return '1;
      3:       return {1'b0, {(W-1){1'b1}}};
      default: return {1'b1, {(W-1){1'b0}}};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [PW-1:0] got,
                             input logic [PW-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // One cycle of stimulus applied just after the edge
  task automatic send(input logic valid, input logic [W-1:0] a, input logic [W-1:0] b);
    @(posedge clk);
    in_valid <= valid;
    op_a     <= a;
    op_b     <= b;
  endtask

  task automatic send_random(input logic valid);
    logic [W-1:0] a;
    logic [W-1:0] b;
    rng_state = xorshift(rng_state);
    a = rng_state[W-1:0];
    rng_state = xorshift(rng_state);
    b = rng_state[W-1:0];
    send(valid, a, b);
  endtask

  ////////////////////
  // Model and monitor
  ////////////////////

  // Ports are sampled before the edge updates them
  // These are the same values the DUT sees
  always @(posedge clk) begin
    logic signed [PW-1:0] ext_a;
    logic signed [PW-1:0] ext_b;
    cycle = cycle + 1;
    if (reset) begin
      held_product = '0;
    end else begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("ERROR: out_valid high with no accepted operation pending");
        end else begin
          held_product = exp_q.pop_front();
          check_value("product", product, held_product);
          check_value("out_valid cycle", PW'(cycle), PW'(cyc_q.pop_front() + 2));
        end
      end else begin
        // Between results the port keeps the last product
        check_value("product", product, held_product);
      end
      if (in_valid) begin
        ext_a = {{W{op_a[W-1]}}, op_a};
        ext_b = {{W{op_b[W-1]}}, op_b};
        exp_q.push_back(ext_a * ext_b);
        cyc_q.push_back(cycle);
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    reset        = 1'b1;
    in_valid     = 1'b0;
    op_a         = '0;
    op_b         = '0;
    rng_state    = 32'hd2a09bba;
    cycle        = 0;
    err_count    = 0;
    check_count  = 0;
    held_product = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // Idle cycles after reset
    // The monitor flags any stray out_valid
    repeat (IDLE_CYCLES) send(1'b0, '0, '0);
    // Every pairing of the corner operands back to back
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send(1'b1, corner_value(i), corner_value(j));
      end
    end
    send(1'b0, '0, '0);
    repeat (RAND_OPS) send_random(1'b1);
    // About half the cycles accepted
    // Idle operands still toggle
    for (int k = 0; k < SPARSE_CYCLES; k++) begin
      rng_state = xorshift(rng_state);
      send_random(rng_state[31]);
    end
    send(1'b0, '0, '0);
    while (exp_q.size() != 0) @(posedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Run length bound with some margin over the test cycles
  initial begin
    #((TEST_CYCLES + 20) * CLK_PERIOD);
    $display("ERROR: timeout, the test sequence did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* booth_mult.f */
rtl/booth_mult_pkg.sv
rtl/booth_pp_gen.sv
rtl/csa_3to2.sv
rtl/csa_nto2.sv
rtl/product_adder.sv
rtl/booth_mult.sv
test/booth_mult_chk.sv
test/booth_mult_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the booth_mult testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module booth_mult_tb \
  -f booth_mult.f -Mdir obj_dir
status=0
out=$(./obj_dir/Vbooth_mult_tb) || status=$?
printf '%s\n' "$out"
if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
